// ==== common/axi_wb_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Shared widths, types and state encodings for the AXI4 slave to
// pipelined Wishbone bridge. Every RTL module and the testbench pull
// these in with a wildcard import of axi_wb_pkg.
//////////////////////////////////////////////////////////////////////
`default_nettype none

package axi_wb_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////////////////////////
	localparam int AXI_ID_W = 4;
	localparam int AXI_ADDR_W = 28;
	// Word address, byte lane bits dropped
	localparam int WB_AW = AXI_ADDR_W - 2;
	localparam int DW = 32;
	// Read beat queue depth is 2**LGFIFO
	localparam int LGFIFO = 4;

	//////////////////////////////////////////////////////////////////////
	// Vector types
	//////////////////////////////////////////////////////////////////////
	typedef logic [AXI_ID_W-1:0] axi_id_t;
	typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
	typedef logic [WB_AW-1:0] wb_addr_t;
	typedef logic [DW-1:0] bus_data_t;
	typedef logic [DW/8-1:0] bus_sel_t;
	typedef logic [7:0] burst_len_t;
	typedef logic [LGFIFO-1:0] fifo_ptr_t;
	typedef logic [1:0] axi_resp_t;

	// Error bit copied into both resp bits
	localparam axi_resp_t RESP_OKAY = 2'b00;
	localparam axi_resp_t RESP_ERR = 2'b11;

	//////////////////////////////////////////////////////////////////////
	// AXI channel payloads
	//////////////////////////////////////////////////////////////////////
	// Address request, incr clear means FIXED
	typedef struct packed {
		axi_id_t id;
		axi_addr_t addr;
		burst_len_t len;
		logic incr;
	} axi_ar_t;

	typedef struct packed {
		axi_id_t id;
		axi_addr_t addr;
		burst_len_t len;
		logic incr;
	} axi_aw_t;

	typedef struct packed {
		bus_data_t data;
		bus_sel_t strb;
		logic last;
	} axi_w_t;

	typedef struct packed {
		axi_id_t id;
		bus_data_t data;
		axi_resp_t resp;
		logic last;
	} axi_r_t;

	typedef struct packed {
		axi_id_t id;
		axi_resp_t resp;
	} axi_b_t;

	//////////////////////////////////////////////////////////////////////
	// Wishbone request and reply
	//////////////////////////////////////////////////////////////////////
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		wb_addr_t addr;
		bus_data_t data;
		bus_sel_t sel;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		logic stall;
		logic err;
		bus_data_t data;
	} wb_rsp_t;

	// Write burst FSM
	typedef enum logic [1:0] {
		WR_IDLE,
		WR_ISSUE,
		WR_WAIT,
		WR_RESP
	} wr_state_t;

	// Bus owner
	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_RD,
		ARB_WR
	} arb_state_t;

endpackage

`default_nettype wire

// ==== axim2wb/axi_rd_bridge.sv ====
//////////////////////////////////////////////////////////////////////
// AXI4 read channels to pipelined Wishbone reads. Bursts are split
// into one queue entry per beat and walked by four pointers, so
// several bursts can be in flight and R beats return in order.
//////////////////////////////////////////////////////////////////////
`default_nettype none

module axi_rd_bridge
	import axi_wb_pkg::*;
(
	input wire i_axi_clk,
	input wire i_axi_reset_n,
	// AR channel
	input wire axi_ar_t i_ar,
	input wire i_arvalid,
	output logic o_arready,
	// R channel
	output axi_r_t o_r,
	output logic o_rvalid,
	input wire i_rready,
	// Wishbone master side
	output wb_req_t o_wb,
	input wire wb_rsp_t i_wb
);

	// Per beat entries
	typedef struct packed {
		axi_id_t id;
		logic last;
		wb_addr_t addr;
	} rd_addr_ent_t;

	typedef struct packed {
		logic err;
		bus_data_t data;
	} rd_data_ent_t;

	logic w_reset;
	assign w_reset = !i_axi_reset_n;

	rd_addr_ent_t afifo [0:(1<<LGFIFO)-1];
	rd_data_ent_t dfifo [0:(1<<LGFIFO)-1];

	// head fills, neck issues, torso stores returns, tail retires
	fifo_ptr_t fifo_head, fifo_neck, fifo_torso, fifo_tail;
	fifo_ptr_t next_head, next_neck, next_torso, next_tail;
	fifo_ptr_t neck_after;
	logic fifo_full;

	// Burst expansion state
	logic filling, fill_incr, fill_write;
	burst_len_t fill_len;
	wb_addr_t fill_addr;
	axi_id_t fill_id;

	logic wb_cyc, err_state;
	logic wb_issue, wb_return;
	logic r_load;

	assign next_head = fifo_head + 1'b1;
	assign next_neck = fifo_neck + 1'b1;
	assign next_torso = fifo_torso + 1'b1;
	assign next_tail = fifo_tail + 1'b1;

	// One slot kept empty to tell full from empty
	assign fifo_full = (next_head == fifo_tail);
	assign fill_write = filling && !fifo_full;
	assign o_arready = !filling && !fifo_full;

	//////////////////////////////////////////////////////////////////////
	// Burst to beat expansion
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge i_axi_clk)
	begin
		if (o_arready && i_arvalid)
		begin
			// Word address, byte lanes ignored
			fill_addr <= i_ar.addr[AXI_ADDR_W-1:AXI_ADDR_W-WB_AW];
			fill_id <= i_ar.id;
			fill_incr <= i_ar.incr;
			fill_len <= i_ar.len;
		end else if (fill_write)
		begin
			// FIXED bursts keep the address
			fill_addr <= fill_addr + wb_addr_t'(fill_incr);
			fill_len <= fill_len - 1'b1;
		end
	end

	always_ff @(posedge i_axi_clk)
	begin
		if (w_reset)
		begin
			filling <= 1'b0;
			fifo_head <= '0;
		end else if (o_arready && i_arvalid)
			filling <= 1'b1;
		else if (fill_write)
		begin
			fifo_head <= next_head;
			// Remaining count hits zero on the last beat
			if (fill_len == '0)
				filling <= 1'b0;
		end
	end

	always_ff @(posedge i_axi_clk)
		if (fill_write)
			afifo[fifo_head] <= '{id: fill_id, last: (fill_len == '0), addr: fill_addr};

	//////////////////////////////////////////////////////////////////////
	// Wishbone issue and return
	//////////////////////////////////////////////////////////////////////
	assign o_wb.cyc = wb_cyc;
	assign o_wb.stb = wb_cyc && (fifo_neck != fifo_head);
	assign o_wb.we = 1'b0;
	assign o_wb.addr = afifo[fifo_neck].addr;
	assign o_wb.data = '0;
	assign o_wb.sel = '1;

	assign wb_issue = o_wb.stb && !i_wb.stall;
	assign wb_return = wb_cyc && (i_wb.ack || i_wb.err);
	assign neck_after = wb_issue ? next_neck : fifo_neck;

	always_ff @(posedge i_axi_clk)
	begin
		if (w_reset)
		begin
			wb_cyc <= 1'b0;
			err_state <= 1'b0;
			fifo_neck <= '0;
			fifo_torso <= '0;
		end else
		begin
			if (wb_issue)
				fifo_neck <= next_neck;

			if (err_state)
			begin
				// Mark each aborted beat as an error
				fifo_torso <= next_torso;
				if (next_torso == fifo_neck)
					err_state <= 1'b0;
			end else if (wb_cyc)
			begin
				if (wb_return)
					fifo_torso <= next_torso;
				if (i_wb.err)
				begin
					// Abort, beats still in flight get flagged
					wb_cyc <= 1'b0;
					err_state <= (next_torso != neck_after);
				end else if (!o_wb.stb
					&& ((wb_return ? next_torso : fifo_torso) == fifo_neck))
					wb_cyc <= 1'b0;
			end else if (fifo_neck != fifo_head)
				wb_cyc <= 1'b1;
		end
	end

	// Data lands on the ack edge
	always_ff @(posedge i_axi_clk)
		if (err_state || wb_return)
			dfifo[fifo_torso] <= '{err: err_state || i_wb.err, data: i_wb.data};

	//////////////////////////////////////////////////////////////////////
	// R beat output register
	//////////////////////////////////////////////////////////////////////
	assign r_load = (fifo_tail != fifo_torso) && (!o_rvalid || i_rready);

	always_ff @(posedge i_axi_clk)
	begin
		if (w_reset)
		begin
			fifo_tail <= '0;
			o_rvalid <= 1'b0;
		end else if (r_load)
		begin
			fifo_tail <= next_tail;
			o_rvalid <= 1'b1;
		end else if (i_rready)
			o_rvalid <= 1'b0;
	end

	always_ff @(posedge i_axi_clk)
		if (r_load)
			o_r <= '{id: afifo[fifo_tail].id,
				data: dfifo[fifo_tail].data,
				resp: dfifo[fifo_tail].err ? RESP_ERR : RESP_OKAY,
				last: afifo[fifo_tail].last};

	// Pointer order tail, torso, neck, head holds, so head never laps tail
	assert property (@(posedge i_axi_clk) disable iff (w_reset)
		(fifo_ptr_t'(fifo_torso - fifo_tail) <= fifo_ptr_t'(fifo_neck - fifo_tail))
		&& (fifo_ptr_t'(fifo_neck - fifo_tail) <= fifo_ptr_t'(fifo_head - fifo_tail)));

	// Stalled R beat stays put
	assert property (@(posedge i_axi_clk) disable iff (w_reset)
		o_rvalid && !i_rready |=> o_rvalid && $stable(o_r));

endmodule

`default_nettype wire

// ==== axim2wb/axi_wr_bridge.sv ====
//////////////////////////////////////////////////////////////////////
// AXI4 write channels to pipelined Wishbone writes. One burst at a
// time; each W beat goes out as a Wishbone write in the same cycle
// and a single B response follows the last ack.
//////////////////////////////////////////////////////////////////////
`default_nettype none

module axi_wr_bridge
	import axi_wb_pkg::*;
(
	input wire i_axi_clk,
	input wire i_axi_reset_n,
	// AW channel
	input wire axi_aw_t i_aw,
	input wire i_awvalid,
	output logic o_awready,
	// W channel
	input wire axi_w_t i_w,
	input wire i_wvalid,
	output logic o_wready,
	// B channel
	output axi_b_t o_b,
	output logic o_bvalid,
	input wire i_bready,
	// Wishbone master side
	output wb_req_t o_wb,
	input wire wb_rsp_t i_wb
);

	logic w_reset;
	assign w_reset = !i_axi_reset_n;

	wr_state_t state;

	// Latched burst
	wb_addr_t wr_addr;
	logic wr_incr;
	burst_len_t wr_len;
	axi_id_t b_id;

	// Up to 256 beats, hence nine bits
	logic [8:0] beat_cnt, resp_cnt, resp_cnt_nxt;
	logic wb_cyc, wr_err;
	logic beat_take, wb_return;

	//////////////////////////////////////////////////////////////////////
	// W beat straight onto the bus
	//////////////////////////////////////////////////////////////////////
	assign o_wb.cyc = wb_cyc;
	assign o_wb.stb = (state == WR_ISSUE) && i_wvalid;
	assign o_wb.we = 1'b1;
	assign o_wb.addr = wr_addr;
	assign o_wb.data = i_w.data;
	assign o_wb.sel = i_w.strb;

	// Beat accepted when the bus takes the strobe
	assign o_wready = o_wb.stb && !i_wb.stall;
	assign beat_take = o_wready;

	assign wb_return = wb_cyc && (i_wb.ack || i_wb.err);
	assign resp_cnt_nxt = resp_cnt + {8'd0, wb_return};

	assign o_b = '{id: b_id, resp: wr_err ? RESP_ERR : RESP_OKAY};

	always_ff @(posedge i_axi_clk)
	begin
		if (o_awready && i_awvalid)
		begin
			wr_addr <= i_aw.addr[AXI_ADDR_W-1:AXI_ADDR_W-WB_AW];
			wr_incr <= i_aw.incr;
			wr_len <= i_aw.len;
			b_id <= i_aw.id;
		end else if (beat_take)
			wr_addr <= wr_addr + wb_addr_t'(wr_incr);
	end

	//////////////////////////////////////////////////////////////////////
	// Burst FSM
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge i_axi_clk)
	begin
		if (w_reset)
		begin
			state <= WR_IDLE;
			o_awready <= 1'b0;
			o_bvalid <= 1'b0;
			wb_cyc <= 1'b0;
			wr_err <= 1'b0;
			beat_cnt <= '0;
			resp_cnt <= '0;
		end else
		begin
			// Acks and errs counted in ISSUE and WAIT alike
			if (wb_return)
				resp_cnt <= resp_cnt_nxt;
			// Sticky until the next AW
			if (wb_return && i_wb.err)
				wr_err <= 1'b1;

			case (state)
			WR_IDLE:
				if (o_awready && i_awvalid)
				begin
					state <= WR_ISSUE;
					o_awready <= 1'b0;
					// Ask for the bus right away
					wb_cyc <= 1'b1;
					wr_err <= 1'b0;
					beat_cnt <= '0;
					resp_cnt <= '0;
				end else
					o_awready <= 1'b1;
			WR_ISSUE:
				if (beat_take)
				begin
					beat_cnt <= beat_cnt + 1'b1;
					if (i_w.last)
						state <= WR_WAIT;
				end
			WR_WAIT:
				// Hold cyc until every strobe is answered
				if (resp_cnt_nxt == beat_cnt)
				begin
					wb_cyc <= 1'b0;
					o_bvalid <= 1'b1;
					state <= WR_RESP;
				end
			WR_RESP:
				if (i_bready)
				begin
					o_bvalid <= 1'b0;
					o_awready <= 1'b1;
					state <= WR_IDLE;
				end
			default:
				state <= WR_IDLE;
			endcase
		end
	end

	// Master's wlast agrees with the AW len
	assert property (@(posedge i_axi_clk) disable iff (w_reset)
		beat_take |-> (i_w.last == (beat_cnt == {1'b0, wr_len})));

	// Strobes only in ISSUE and never past the burst length
	assert property (@(posedge i_axi_clk) disable iff (w_reset)
		o_wb.stb |-> (state == WR_ISSUE) && (beat_cnt <= {1'b0, wr_len}));

endmodule

`default_nettype wire

// ==== verilog/wb_arbiter.sv ====
//////////////////////////////////////////////////////////////////////
// Two master Wishbone arbiter. Grants the bus to the read or write
// bridge for a whole cycle and steers the slave reply to the owner;
// the other master sees a stalled, silent bus.
//////////////////////////////////////////////////////////////////////
`default_nettype none

module wb_arbiter
	import axi_wb_pkg::*;
(
	input wire i_axi_clk,
	input wire i_axi_reset_n,
	input wire wb_req_t i_rd_req,
	input wire wb_req_t i_wr_req,
	input wire wb_rsp_t i_bus_rsp,
	output wb_rsp_t o_rd_rsp,
	output wb_rsp_t o_wr_rsp,
	output wb_req_t o_bus_req
);

	logic w_reset;
	assign w_reset = !i_axi_reset_n;

	arb_state_t state;
	// Set when the write bridge owned the last cycle
	logic last_wr;
	wb_rsp_t idle_rsp;

	// Reply seen by a master without the grant
	assign idle_rsp = '{ack: 1'b0, stall: 1'b1, err: 1'b0, data: i_bus_rsp.data};

	always_ff @(posedge i_axi_clk)
	begin
		if (w_reset)
		begin
			state <= ARB_IDLE;
			last_wr <= 1'b0;
		end else
			case (state)
			ARB_IDLE:
				// Both asking, the other side goes first
				if (i_rd_req.cyc && (!i_wr_req.cyc || last_wr))
				begin
					state <= ARB_RD;
					last_wr <= 1'b0;
				end else if (i_wr_req.cyc)
				begin
					state <= ARB_WR;
					last_wr <= 1'b1;
				end
			ARB_RD:
				if (!i_rd_req.cyc)
					state <= ARB_IDLE;
			ARB_WR:
				if (!i_wr_req.cyc)
					state <= ARB_IDLE;
			default:
				state <= ARB_IDLE;
			endcase
	end

	// Owner's request straight to the bus
	always_comb
	begin
		o_bus_req = '0;
		o_rd_rsp = idle_rsp;
		o_wr_rsp = idle_rsp;
		case (state)
		ARB_RD:
		begin
			o_bus_req = i_rd_req;
			o_rd_rsp = i_bus_rsp;
		end
		ARB_WR:
		begin
			o_bus_req = i_wr_req;
			o_wr_rsp = i_bus_rsp;
		end
		default:
			o_bus_req = '0;
		endcase
	end

	// Bus strobe only inside a granted, open cycle
	assert property (@(posedge i_axi_clk) disable iff (w_reset)
		o_bus_req.stb |-> o_bus_req.cyc && (state != ARB_IDLE));

endmodule

`default_nettype wire

// ==== axim2wb/axi_wb_bridge_top.sv ====
//////////////////////////////////////////////////////////////////////
// AXI4 slave to pipelined Wishbone master bridge, top level. Read
// and write bridges run side by side and share one Wishbone bus
// through the arbiter.
//////////////////////////////////////////////////////////////////////
`default_nettype none

module axi_wb_bridge_top
	import axi_wb_pkg::*;
(
	input wire i_axi_clk,
	input wire i_axi_reset_n,
	// Read channels
	input wire axi_ar_t i_ar,
	input wire i_arvalid,
	output logic o_arready,
	output axi_r_t o_r,
	output logic o_rvalid,
	input wire i_rready,
	// Write channels
	input wire axi_aw_t i_aw,
	input wire i_awvalid,
	output logic o_awready,
	input wire axi_w_t i_w,
	input wire i_wvalid,
	output logic o_wready,
	output axi_b_t o_b,
	output logic o_bvalid,
	input wire i_bready,
	// Wishbone bus
	output wb_req_t o_wb,
	input wire wb_rsp_t i_wb
);

	// Bridge to arbiter links
	wb_req_t rd_req, wr_req;
	wb_rsp_t rd_rsp, wr_rsp;

	axi_rd_bridge rd0 (.i_axi_clk, .i_axi_reset_n, .i_ar, .i_arvalid, .o_arready,
		.o_r, .o_rvalid, .i_rready, .o_wb(rd_req), .i_wb(rd_rsp));

	axi_wr_bridge wr0 (.i_axi_clk, .i_axi_reset_n, .i_aw, .i_awvalid, .o_awready,
		.i_w, .i_wvalid, .o_wready, .o_b, .o_bvalid, .i_bready,
		.o_wb(wr_req), .i_wb(wr_rsp));

	wb_arbiter arb0 (.i_axi_clk, .i_axi_reset_n, .i_rd_req(rd_req), .i_wr_req(wr_req),
		.i_bus_rsp(i_wb), .o_rd_rsp(rd_rsp), .o_wr_rsp(wr_rsp), .o_bus_req(o_wb));

endmodule

`default_nettype wire

// ==== tests/tb_wb_slave.sv ====
//////////////////////////////////////////////////////////////////////
// Wishbone slave memory model for the bridge testbench. 256 words,
// stall from an outside random bit, ack one cycle after a strobe is
// taken and err for one chosen word address.
//////////////////////////////////////////////////////////////////////
`default_nettype none

module tb_wb_slave
	import axi_wb_pkg::*;
(
	input wire i_axi_clk,
	input wire i_stall,
	input wire wb_addr_t i_err_addr,
	input wire wb_req_t i_wb,
	output wb_rsp_t o_wb
);

	bus_data_t mem [0:255];

	// Strobe the coming edge will take
	logic pend, pend_we, pend_err;
	logic [7:0] pend_idx;
	bus_data_t pend_data;
	bus_sel_t pend_sel;

	initial
	begin
		o_wb = '0;
		pend = 1'b0;
		pend_we = 1'b0;
		pend_err = 1'b0;
		pend_idx = '0;
		pend_data = '0;
		pend_sel = '0;
	end

	always @(negedge i_axi_clk)
	begin
		// No reply once the master has dropped cyc
		o_wb.ack = pend && !pend_err && i_wb.cyc;
		o_wb.err = pend && pend_err && i_wb.cyc;
		if (o_wb.ack && pend_we)
		begin
			for (int b = 0; b < DW/8; b++)
				if (pend_sel[b])
					mem[pend_idx][8*b +: 8] = pend_data[8*b +: 8];
		end else if (o_wb.ack)
			o_wb.data = mem[pend_idx];
		o_wb.stall = i_stall;

		// New inputs settle, then look at what the next edge takes
		#1;
		pend = i_wb.cyc && i_wb.stb && !o_wb.stall;
		pend_we = i_wb.we;
		pend_err = (i_wb.addr == i_err_addr);
		pend_idx = i_wb.addr[7:0];
		pend_data = i_wb.data;
		pend_sel = i_wb.sel;
	end

endmodule

`default_nettype wire

// ==== tests/tb_axi_wb_bridge.sv ====
//////////////////////////////////////////////////////////////////////
// Directed testbench for the AXI4 to Wishbone bridge. AXI channels
// are driven on the falling edge and every R and B beat is checked
// against a shadow memory; error counts close the run.
//////////////////////////////////////////////////////////////////////
`default_nettype none

module tb_axi_wb_bridge
	import axi_wb_pkg::*;
();

	localparam int CLK_PERIOD = 100;
	localparam int N_TESTS = 6;
	localparam int CYCLES_PER_TEST = 400;
	// Slave answers err for this word
	localparam wb_addr_t ERR_ADDR = 26'h0c0;

	logic axi_clk, axi_reset_n;
	axi_ar_t ar;
	logic arvalid, arready, rvalid, rready;
	axi_r_t r;
	axi_aw_t aw;
	logic awvalid, awready;
	axi_w_t w;
	logic wvalid, wready, bvalid, bready;
	axi_b_t b;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;

	logic [31:0] lfsr;
	logic stall_en, stall_rnd, rnd_rready;
	bus_data_t shadow [0:255];
	bus_data_t wbeats [0:255];
	int data_errs, resp_errs, id_errs, last_errs;

	axi_wb_bridge_top dut0 (.i_axi_clk(axi_clk), .i_axi_reset_n(axi_reset_n),
		.i_ar(ar), .i_arvalid(arvalid), .o_arready(arready),
		.o_r(r), .o_rvalid(rvalid), .i_rready(rready),
		.i_aw(aw), .i_awvalid(awvalid), .o_awready(awready),
		.i_w(w), .i_wvalid(wvalid), .o_wready(wready),
		.o_b(b), .o_bvalid(bvalid), .i_bready(bready),
		.o_wb(wb_req), .i_wb(wb_rsp));

	tb_wb_slave slave0 (.i_axi_clk(axi_clk), .i_stall(stall_rnd), .i_err_addr(ERR_ADDR),
		.i_wb(wb_req), .o_wb(wb_rsp));

	always #(CLK_PERIOD/2) axi_clk = ~axi_clk;

	//////////////////////////////////////////////////////////////////////
	// Random bits and memory contents
	//////////////////////////////////////////////////////////////////////
	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic rand_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic bus_data_t rand_word();
		bus_data_t v;
		for (int i = 0; i < DW; i++)
			v[i] = rand_bit();
		return v;
	endfunction

	// Every byte depends on the whole address
	function automatic bus_data_t fill_word(input logic [7:0] a);
		return {a, ~a, a ^ 8'h3c, 8'h96 + a};
	endfunction

	function automatic bus_data_t merge_bytes(input bus_data_t old_w, input bus_data_t new_w,
		input bus_sel_t sel);
		bus_data_t v;
		v = old_w;
		for (int i = 0; i < DW/8; i++)
			if (sel[i])
				v[8*i +: 8] = new_w[8*i +: 8];
		return v;
	endfunction

	// Stall picked on the rising edge, used by the slave on the falling one
	always @(posedge axi_clk)
		stall_rnd <= stall_en && rand_bit();

	//////////////////////////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////////////////////////
	task automatic cmp_data(input string name, input bus_data_t exp, input bus_data_t got);
		if (got !== exp)
		begin
			data_errs++;
			$display("ERR %s exp %h got %h", name, exp, got);
		end
	endtask

	task automatic cmp_resp(input string name, input axi_resp_t exp, input axi_resp_t got);
		if (got !== exp)
		begin
			resp_errs++;
			$display("ERR %s exp %h got %h", name, exp, got);
		end
	endtask

	task automatic cmp_id(input string name, input axi_id_t exp, input axi_id_t got);
		if (got !== exp)
		begin
			id_errs++;
			$display("ERR %s exp %h got %h", name, exp, got);
		end
	endtask

	task automatic cmp_last(input string name, input logic exp, input logic got);
		if (got !== exp)
		begin
			last_errs++;
			$display("ERR %s exp %h got %h", name, exp, got);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// AXI master tasks
	//////////////////////////////////////////////////////////////////////
	// Burst of len+1 beats from wbeats, all with one strobe value
	task automatic axi_write(input axi_id_t tid, input wb_addr_t base, input burst_len_t len,
		input logic incr, input bus_sel_t strb);
		wb_addr_t beat_addr;
		logic hit_err;
		@(negedge axi_clk);
		aw = '{id: tid, addr: {base, 2'b00}, len: len, incr: incr};
		awvalid = 1'b1;
		#1;
		while (!awready)
		begin
			@(negedge axi_clk);
			#1;
		end
		@(negedge axi_clk);
		awvalid = 1'b0;
		for (int beat = 0; beat <= int'(len); beat++)
		begin
			w = '{data: wbeats[beat], strb: strb, last: (beat == int'(len))};
			wvalid = 1'b1;
			#1;
			while (!wready)
			begin
				@(negedge axi_clk);
				#1;
			end
			@(negedge axi_clk);
		end
		wvalid = 1'b0;
		bready = 1'b1;
		#1;
		while (!bvalid)
		begin
			@(negedge axi_clk);
			#1;
		end
		// Shadow takes every beat except the faulting word
		hit_err = 1'b0;
		for (int beat = 0; beat <= int'(len); beat++)
		begin
			beat_addr = incr ? base + wb_addr_t'(beat) : base;
			if (beat_addr == ERR_ADDR)
				hit_err = 1'b1;
			else
				shadow[beat_addr[7:0]] = merge_bytes(shadow[beat_addr[7:0]],
					wbeats[beat], strb);
		end
		cmp_id("bid", tid, b.id);
		cmp_resp("bresp", hit_err ? RESP_ERR : RESP_OKAY, b.resp);
		@(negedge axi_clk);
		bready = 1'b0;
	endtask

	task automatic axi_read(input axi_id_t tid, input wb_addr_t base, input burst_len_t len,
		input logic incr);
		wb_addr_t beat_addr;
		int beat;
		@(negedge axi_clk);
		ar = '{id: tid, addr: {base, 2'b00}, len: len, incr: incr};
		arvalid = 1'b1;
		#1;
		while (!arready)
		begin
			@(negedge axi_clk);
			#1;
		end
		@(negedge axi_clk);
		arvalid = 1'b0;
		beat = 0;
		while (beat <= int'(len))
		begin
			rready = rnd_rready ? rand_bit() : 1'b1;
			#1;
			if (rvalid && rready)
			begin
				beat_addr = incr ? base + wb_addr_t'(beat) : base;
				cmp_id("rid", tid, r.id);
				cmp_last("rlast", beat == int'(len), r.last);
				if (beat_addr == ERR_ADDR)
					cmp_resp("rresp", RESP_ERR, r.resp);
				else
				begin
					cmp_resp("rresp", RESP_OKAY, r.resp);
					cmp_data("rdata", shadow[beat_addr[7:0]], r.data);
				end
				beat++;
			end
			@(negedge axi_clk);
		end
		rready = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////
	task automatic single_write_read();
		wbeats[0] = 32'h12345678;
		axi_write(4'h3, 26'h010, 8'd0, 1'b1, 4'hf);
		axi_read(4'h5, 26'h010, 8'd0, 1'b1);
	endtask

	task automatic incr_burst();
		for (int i = 0; i < 8; i++)
			wbeats[i] = rand_word();
		axi_write(4'h6, 26'h020, 8'd7, 1'b1, 4'hf);
		axi_read(4'h7, 26'h020, 8'd7, 1'b1);
	endtask

	task automatic partial_strobe();
		wbeats[0] = 32'ha5a5a5a5;
		axi_write(4'h1, 26'h030, 8'd0, 1'b1, 4'hf);
		// Bytes 0 and 2 only
		wbeats[0] = 32'h11223344;
		axi_write(4'h2, 26'h030, 8'd0, 1'b1, 4'b0101);
		axi_read(4'h3, 26'h030, 8'd0, 1'b1);
	endtask

	task automatic fixed_read();
		axi_read(4'h8, 26'h020, 8'd3, 1'b0);
	endtask

	task automatic error_responses();
		axi_read(4'h9, ERR_ADDR, 8'd0, 1'b1);
		// Faulting word on the last beat
		axi_read(4'ha, ERR_ADDR - 26'd3, 8'd3, 1'b1);
		for (int i = 0; i < 4; i++)
			wbeats[i] = rand_word();
		axi_write(4'hb, ERR_ADDR - 26'd1, 8'd3, 1'b1, 4'hf);
	endtask

	task automatic concurrent_rd_wr();
		stall_en = 1'b1;
		rnd_rready = 1'b1;
		for (int i = 0; i < 8; i++)
			wbeats[i] = rand_word();
		fork
			axi_read(4'h2, 26'h020, 8'd7, 1'b1);
			axi_write(4'hc, 26'h060, 8'd7, 1'b1, 4'hf);
		join
		axi_read(4'hd, 26'h060, 8'd7, 1'b1);
		stall_en = 1'b0;
		rnd_rready = 1'b0;
	endtask

	initial
	begin
		axi_clk = 1'b0;
		axi_reset_n = 1'b0;
		ar = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		aw = '0;
		awvalid = 1'b0;
		w = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		lfsr = 32'h02f96551;
		stall_en = 1'b0;
		stall_rnd = 1'b0;
		rnd_rready = 1'b0;
		data_errs = 0;
		resp_errs = 0;
		id_errs = 0;
		last_errs = 0;
		// Same known contents in the model and the shadow
		for (int i = 0; i < 256; i++)
		begin
			shadow[i] = fill_word(8'(i));
			slave0.mem[i] = fill_word(8'(i));
		end
		repeat (4) @(posedge axi_clk);
		@(negedge axi_clk);
		axi_reset_n = 1'b1;

		single_write_read();
		incr_burst();
		partial_strobe();
		fixed_read();
		error_responses();
		concurrent_rd_wr();

		$display("error counts: data %0d resp %0d id %0d last %0d",
			data_errs, resp_errs, id_errs, last_errs);
		if (data_errs + resp_errs + id_errs + last_errs == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	// Watchdog sized from the test count
	initial
	begin
		#(N_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
		$display("timeout: tests still running after %0d cycles", N_TESTS * CYCLES_PER_TEST);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
common/axi_wb_pkg.sv
axim2wb/axi_rd_bridge.sv
axim2wb/axi_wr_bridge.sv
verilog/wb_arbiter.sv
axim2wb/axi_wb_bridge_top.sv
tests/tb_wb_slave.sv
tests/tb_axi_wb_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the bridge testbench with Verilator, run it, judge by the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_axi_wb_bridge -Mdir obj_dir -f sim.f

./obj_dir/Vtb_axi_wb_bridge | tee sim.log

if grep -q '^TESTS PASSED$' sim.log; then
	exit 0
fi
echo "simulation failed, see sim.log"
exit 1
